// ==== filelist.f ====
tinker_pkg.sv
tinker_decoder.sv
tinker_regfile.sv
tinker_alu.sv
tinker_branch_unit.sv
tinker_sequencer.sv
tinker_core.sv
tb_tinker_core.sv

// ==== Bender.yml ====
package:
  name: tinker_core

sources:
  - tinker_pkg.sv
  - tinker_decoder.sv
  - tinker_regfile.sv
  - tinker_alu.sv
  - tinker_branch_unit.sv
  - tinker_sequencer.sv
  - tinker_core.sv
  - target: test
    files:
      - tb_tinker_core.sv

// ==== tb_tinker_core.sv ====
`timescale 1ns/1ps

module tb_tinker_core import tinker_pkg::*; ();
    logic            clk = 1'b0;
    logic            reset = 1'b1;
    mem_req_t        mem_req;
    logic            mem_req_valid;
    logic            mem_req_ready = 1'b0;
    logic            mem_rsp_valid = 1'b0;
    logic [XLEN-1:0] mem_rsp_data = '0;
    logic            hlt;

    logic [7:0]      mem [logic [63:0]]; // Byte addressed, little-endian
    logic [31:0]     prog [$];
    mem_req_t        exp_q [$];          // Requests the model expects, in order
    string           test_name;
    int              errors = 0;
    int              rsp_errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    int              stall_left = 0;
    int              rsp_left = 0;
    logic [XLEN-1:0] rsp_word = '0;
    logic            held = 1'b0;
    mem_req_t        held_req = '0;

    tinker_core u_dut (.clk(clk), .reset(reset), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data), .hlt(hlt));

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic int pick(input int n);
        return $urandom_range(n - 1, 0);
    endfunction

    function automatic logic [31:0] enc_r(input opcode_e op, input int d, input int s,
                                          input int t);
        return {op, d[4:0], s[4:0], t[4:0], 12'h000};
    endfunction

    function automatic logic [31:0] enc_l(input opcode_e op, input int d, input int s,
                                          input int imm);
        return {op, d[4:0], s[4:0], 5'b00000, imm[11:0]};
    endfunction

    function automatic mem_req_t make_req(input logic wr, input logic word, input logic [63:0] addr,
                                          input logic [63:0] wdata);
        mem_req_t m;
        m.write = wr;
        m.word  = word;
        m.addr  = addr;
        m.wdata = wdata;
        return m;
    endfunction

    function automatic logic [63:0] read_mem(input logic [63:0] addr, input int nbytes);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (mem.exists(addr + 64'(i))) v[8*i +: 8] = mem[addr + 64'(i)]; // Unwritten reads 0
        end
        return v;
    endfunction

    task automatic write_mem(input logic [63:0] addr, input logic [63:0] data, input int nbytes);
        for (int i = 0; i < nbytes; i++) begin
            mem[addr + 64'(i)] = data[8*i +: 8];
        end
    endtask

    // Instruction level model that fills exp_q with every request the core should make
    task automatic run_model();
        logic [63:0] r [32];
        logic [63:0] pc, npc, imm, sv, tv, dv, val;
        logic [63:0] fetched;
        logic [31:0] w;
        logic [4:0]  d, s, t;
        opcode_e     op;
        bit          wr;
        for (int i = 0; i < 32; i++) r[i] = '0;
        pc = RESET_PC;
        for (int step = 0; step < 5000; step++) begin
            exp_q.push_back(make_req(1'b0, 1'b0, pc, '0));
            fetched = read_mem(pc, 4);
            w = fetched[31:0];
            op = opcode_e'(w[31:27]);
            if (op == OP_HALT) return;
            d = w[26:22];
            s = w[21:17];
            t = w[16:12];
            imm = {{52{w[11]}}, w[11:0]};
            sv = r[s];
            tv = r[t];
            dv = r[d];
            npc = pc + INSTR_BYTES;
            wr = 1'b1;
            val = '0;
            case (op)
                OP_AND:    val = sv & tv;
                OP_OR:     val = sv | tv;
                OP_XOR:    val = sv ^ tv;
                OP_NOT:    val = ~sv;
                OP_SHFTR:  val = sv >> tv[5:0];
                OP_SHFTRI: val = sv >> imm[5:0];
                OP_SHFTL:  val = sv << tv[5:0];
                OP_SHFTLI: val = sv << imm[5:0];
                OP_ADD:    val = sv + tv;
                OP_ADDI:   val = dv + imm; // Accumulates into rd
                OP_SUB:    val = sv - tv;
                OP_SUBI:   val = dv - imm;
                OP_MUL:    val = sv * tv;
                OP_MOV_R:  val = sv;
                OP_MOV_L:  val = imm;
                OP_LOAD: begin
                    exp_q.push_back(make_req(1'b0, 1'b1, sv + imm, '0));
                    val = read_mem(sv + imm, 8);
                end
                OP_STORE: begin
                    wr = 1'b0;
                    exp_q.push_back(make_req(1'b1, 1'b1, dv + imm, sv));
                    write_mem(dv + imm, sv, 8);
                end
                default: begin
                    wr = 1'b0; // Branches and unused opcodes
                    if (op == OP_BR) npc = dv;
                    if (op == OP_BRR_R) npc = pc + dv;
                    if (op == OP_BRR_L) npc = pc + imm;
                    if (op == OP_BRNZ && sv != '0) npc = dv;
                    if (op == OP_BRGT && $signed(sv) > $signed(tv)) npc = dv;
                end
            endcase
            if (wr && d != 5'd0) r[d] = val;
            pc = npc;
        end
    endtask

    task automatic accept_request();
        mem_req_t want;
        if (exp_q.size() == 0) begin
            $display("Test %s: core issued a request the model did not expect", test_name);
            rsp_errors++;
        end else begin
            want = exp_q.pop_front();
            assert (mem_req == want) else begin
                $display("FAILED %s: expected %h actual %h", test_name, want, mem_req);
                rsp_errors++;
            end
        end
        if (mem_req.write) begin
            write_mem(mem_req.addr, mem_req.wdata, 8);
        end else begin
            rsp_word = read_mem(mem_req.addr, mem_req.word ? 8 : 4);
            rsp_left = $urandom_range(4, 1);
        end
    endtask

    // Memory with random back-pressure and response delay
    always @(posedge clk) begin
        mem_rsp_valid <= 1'b0;
        if (reset) begin
            stall_left = 0;
            rsp_left = 0;
            held = 1'b0;
            mem_req_ready <= 1'b0;
        end else begin
            if (held) begin
                assert (mem_req_valid && mem_req == held_req) else begin
                    $display("FAILED %s held request: expected %h actual %h", test_name,
                             held_req, mem_req);
                    rsp_errors++;
                end
            end
            held = mem_req_valid && !mem_req_ready;
            held_req = mem_req;
            if (rsp_left > 0) begin
                rsp_left--;
                if (rsp_left == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= rsp_word;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                accept_request();
                stall_left = $urandom_range(3, 0);
            end else if (stall_left > 0) begin
                stall_left--;
            end
            mem_req_ready <= (stall_left == 0);
        end
    end

    // Stores r0 to r31 at address 8*i
    task automatic append_reg_dump();
        for (int i = 0; i < 32; i++) prog.push_back(enc_l(OP_STORE, 0, i, 8 * i));
    endtask

    task automatic build_alu_program();
        opcode_e ops [15];
        opcode_e op;
        ops = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
                OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL, OP_MOV_R, OP_MOV_L};
        for (int i = 0; i < 40; i++) begin
            op = (i < 8) ? OP_MOV_L : ops[pick(15)]; // Seed some registers first
            if (op inside {OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_L}) begin
                prog.push_back(enc_l(op, (i < 8) ? i + 1 : pick(32), pick(32), $urandom));
            end else begin
                prog.push_back(enc_r(op, pick(32), pick(32), pick(32)));
            end
        end
        append_reg_dump();
    endtask

    task automatic build_mem_program();
        prog.push_back(enc_l(OP_MOV_L, 1, 0, 1));
        prog.push_back(enc_l(OP_SHFTLI, 1, 1, 15)); // r1 = 0x8000
        for (int i = 2; i < 10; i++) prog.push_back(enc_l(OP_MOV_L, i, 0, $urandom));
        for (int i = 0; i < 30; i++) begin
            case (pick(3))
                0:       prog.push_back(enc_l(OP_STORE, 1, pick(32), pick(128)));
                1:       prog.push_back(enc_l(OP_LOAD, 2 + pick(30), 1, pick(128)));
                default: prog.push_back(enc_r(OP_ADD, 2 + pick(30), pick(32), pick(32)));
            endcase
        end
        append_reg_dump();
    endtask

    // Forward branches over addi fillers on r7, so every program ends
    task automatic build_branch_program();
        int kind, skip, target;
        prog.push_back(enc_l(OP_MOV_L, 2, 0, 1));
        prog.push_back(enc_l(OP_SHFTLI, 2, 2, 13)); // r2 = RESET_PC
        for (int seg = 0; seg < 12; seg++) begin
            kind = pick(5);
            skip = 1 + pick(2);
            if (kind == 3) prog.push_back(enc_l(OP_MOV_L, 5, 0, pick(2) ? pick(4096) : 0));
            if (kind == 4) begin
                prog.push_back(enc_l(OP_MOV_L, 5, 0, pick(4096)));
                prog.push_back(enc_l(OP_MOV_L, 6, 0, pick(4096)));
            end
            if (kind == 2) begin
                prog.push_back(enc_l(OP_BRR_L, 0, 0, 4 * (skip + 1)));
            end else if (kind == 1) begin
                prog.push_back(enc_l(OP_MOV_L, 4, 0, 4 * (skip + 1)));
                prog.push_back(enc_r(OP_BRR_R, 4, 0, 0));
            end else begin
                target = 4 * (prog.size() + 3 + skip); // Absolute, relative to r2
                prog.push_back(enc_l(OP_MOV_L, 4, 0, target));
                prog.push_back(enc_r(OP_ADD, 4, 4, 2));
                prog.push_back(enc_r(kind == 0 ? OP_BR : (kind == 3 ? OP_BRNZ : OP_BRGT), 4, 5, 6));
            end
            for (int i = 0; i < skip; i++) prog.push_back(enc_l(OP_ADDI, 7, 0, 1));
        end
        prog.push_back(enc_l(OP_STORE, 0, 7, 0));
    endtask

    task automatic run_test(input string name, input int kind);
        logic [7:0] init_mem [logic [63:0]];
        int         start_errors;
        int         cycles;
        state_e     st;
        test_name = name;
        start_errors = errors + rsp_errors;
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!hlt && !mem_req_valid) else begin
            $display("Test %s: hlt or mem_req_valid is high during reset", name);
            errors++;
        end
        prog.delete();
        if (kind == 1) build_alu_program();
        if (kind == 2) build_mem_program();
        if (kind == 3) build_branch_program();
        prog.push_back(enc_r(OP_HALT, 0, 0, 0));
        mem.delete();
        foreach (prog[i]) write_mem(RESET_PC + 64'(4 * i), {32'h0, prog[i]}, 4);
        init_mem = mem;
        exp_q.delete();
        run_model();
        mem = init_mem;
        @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!hlt && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!hlt) begin
            st = u_dut.u_sequencer.state;
            $display("Test %s: timeout, no halt within 2000 cycles, core in state %s", name,
                     st.name());
            errors++;
        end else begin
            assert (exp_q.size() == 0) else begin
                $display("Test %s: %0d expected requests were never issued", name,
                         exp_q.size());
                errors++;
            end
            repeat (50) begin
                @(negedge clk);
                assert (hlt && !mem_req_valid) else begin
                    $display("Test %s: core left halt or issued a request", name);
                    errors++;
                end
            end
        end
        tests_run++;
        if (errors + rsp_errors == start_errors) begin
            $display("%-12s ok", name);
        end else begin
            tests_failed++;
            $display("%-12s failed, %0d errors", name, errors + rsp_errors - start_errors);
        end
    endtask

    initial begin
        void'($urandom(72134));
        run_test("reset_halt", 0);
        for (int i = 0; i < 3; i++) run_test($sformatf("alu_%0d", i), 1);
        for (int i = 0; i < 2; i++) run_test($sformatf("load_store_%0d", i), 2);
        for (int i = 0; i < 2; i++) run_test($sformatf("branch_%0d", i), 3);
        $display("Tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
                 tests_failed);
        if (errors + rsp_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tinker_core.sv ====
`timescale 1ns/1ps

module tinker_core import tinker_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output mem_req_t        mem_req,
    output logic            mem_req_valid,
    input  logic            mem_req_ready,
    input  logic            mem_rsp_valid,
    input  logic [XLEN-1:0] mem_rsp_data,
    output logic            hlt
);
    instr_u                instr;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [XLEN-1:0]       imm;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  is_halt;
    logic                  writes_rd;
    logic                  use_literal;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic [XLEN-1:0]       rd_val;
    logic                  reg_we;
    logic [XLEN-1:0]       reg_wdata;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       alu_result;

    assign op_a = is_store ? rd_val : rs_val; // Store base lives in rd
    assign op_b = use_literal ? imm : rt_val;

    tinker_sequencer u_sequencer (
        .clk(clk), .reset(reset),
        .is_load(is_load), .is_store(is_store), .is_branch(is_branch),
        .is_halt(is_halt), .writes_rd(writes_rd),
        .next_pc(next_pc), .alu_result(alu_result), .store_data(rs_val),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data),
        .instr(instr), .pc(pc), .reg_we(reg_we), .reg_wdata(reg_wdata),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .hlt(hlt)
    );

    tinker_decoder u_decoder (
        .instr(instr), .opcode(opcode), .rd(rd), .rs(rs), .rt(rt), .imm(imm),
        .is_load(is_load), .is_store(is_store), .is_branch(is_branch),
        .is_halt(is_halt), .writes_rd(writes_rd), .use_literal(use_literal)
    );

    tinker_regfile u_regfile (
        .clk(clk), .reset(reset),
        .we(reg_we), .waddr(rd), .wdata(reg_wdata),
        .raddr_s(rs), .raddr_t(rt), .raddr_d(rd),
        .rdata_s(rs_val), .rdata_t(rt_val), .rdata_d(rd_val)
    );

    tinker_alu u_alu (
        .opcode(opcode), .op_a(op_a), .op_b(op_b), .result(alu_result)
    );

    tinker_branch_unit u_branch (
        .opcode(opcode), .pc(pc),
        .rs_val(rs_val), .rt_val(rt_val), .rd_val(rd_val), .imm(imm),
        .next_pc(next_pc)
    );

endmodule

// ==== tinker_sequencer.sv ====
`timescale 1ns/1ps

module tinker_sequencer import tinker_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            is_branch,
    input  logic            is_halt,
    input  logic            writes_rd,
    input  logic [XLEN-1:0] next_pc,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] store_data,
    input  logic            mem_req_ready,
    input  logic            mem_rsp_valid,
    input  logic [XLEN-1:0] mem_rsp_data,
    output instr_u          instr,
    output logic [XLEN-1:0] pc,
    output logic            reg_we,
    output logic [XLEN-1:0] reg_wdata,
    output mem_req_t        mem_req,
    output logic            mem_req_valid,
    output logic            hlt
);
    state_e          state;
    logic            rsp_wait; // Read accepted, data not back yet
    logic            req_fire;
    logic            rsp_fire;
    logic [XLEN-1:0] alu_q;
    logic [XLEN-1:0] load_q;

    assign mem_req_valid = !reset && (state == FETCH || state == MEMORY) && !rsp_wait;
    assign req_fire      = mem_req_valid && mem_req_ready;
    assign rsp_fire      = rsp_wait && mem_rsp_valid;

    assign hlt       = (state == HALTED);
    assign reg_we    = (state == WRITEBACK) && writes_rd;
    assign reg_wdata = is_load ? load_q : alu_q;

    // Request fields depend only on held state, so they stay stable under back-pressure
    always_comb begin
        mem_req = '0;
        if (state == MEMORY) begin
            mem_req.write = is_store;
            mem_req.word  = 1'b1;
            mem_req.addr  = alu_q;
            mem_req.wdata = is_store ? store_data : '0;
        end else begin
            mem_req.addr = pc; // Instruction fetch
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= FETCH;
            pc       <= RESET_PC;
            rsp_wait <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (req_fire) begin
                        rsp_wait <= 1'b1;
                    end else if (rsp_fire) begin
                        rsp_wait <= 1'b0;
                        state    <= DECODE;
                    end
                end
                DECODE: begin
                    state <= is_halt ? HALTED : EXECUTE;
                end
                EXECUTE: begin
                    if (is_branch) begin
                        pc    <= next_pc; // Not taken gives pc + 4
                        state <= FETCH;
                    end else if (is_load || is_store) begin
                        state <= MEMORY;
                    end else begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (req_fire) begin
                        if (is_load) begin
                            rsp_wait <= 1'b1;
                        end else begin
                            state <= WRITEBACK; // Stores get no response
                        end
                    end else if (rsp_fire) begin
                        rsp_wait <= 1'b0;
                        state    <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    pc    <= pc + INSTR_BYTES;
                    state <= FETCH;
                end
                HALTED:  state <= HALTED;
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && rsp_fire) begin
            instr <= mem_rsp_data[ILEN-1:0];
        end
        if (state == EXECUTE) begin
            alu_q <= alu_result;
        end
        if (state == MEMORY && rsp_fire) begin
            load_q <= mem_rsp_data;
        end
    end

endmodule

// ==== tinker_branch_unit.sv ====
`timescale 1ns/1ps

module tinker_branch_unit import tinker_pkg::*; (
    input  opcode_e         opcode,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs_val,
    input  logic [XLEN-1:0] rt_val,
    input  logic [XLEN-1:0] rd_val,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] next_pc
);
    logic [XLEN-1:0] seq_pc;

    assign seq_pc = pc + INSTR_BYTES;

    always_comb begin
        case (opcode)
            OP_BR:    next_pc = rd_val;
            OP_BRR_R: next_pc = pc + rd_val;
            OP_BRR_L: next_pc = pc + imm;
            OP_BRNZ: begin
                next_pc = (rs_val != '0) ? rd_val : seq_pc;
            end
            OP_BRGT: begin
                // Signed compare
                if ($signed(rs_val) > $signed(rt_val)) begin
                    next_pc = rd_val;
                end else begin
                    next_pc = seq_pc;
                end
            end
            default:  next_pc = seq_pc;
        endcase
    end

endmodule

// ==== tinker_alu.sv ====
`timescale 1ns/1ps

module tinker_alu import tinker_pkg::*; (
    input  opcode_e         opcode,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic [XLEN-1:0] result
);
    logic [5:0] shamt;

    assign shamt = op_b[5:0];

    always_comb begin
        case (opcode)
            OP_ADD,
            OP_ADDI:   result = op_a + op_b;
            OP_SUB,
            OP_SUBI:   result = op_a - op_b;
            OP_MUL:    result = op_a * op_b; // Low half only
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;
            OP_SHFTR,
            OP_SHFTRI: result = op_a >> shamt;
            OP_SHFTL,
            OP_SHFTLI: result = op_a << shamt;
            OP_MOV_R:  result = op_a;
            OP_MOV_L:  result = op_b;
            // Effective address from rs for load and rd for store
            OP_LOAD,
            OP_STORE:  result = op_a + op_b;
            default:   result = '0;
        endcase
    end

endmodule

// ==== tinker_regfile.sv ====
`timescale 1ns/1ps

module tinker_regfile import tinker_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr_s,
    input  logic [REG_ADDR_W-1:0] raddr_t,
    input  logic [REG_ADDR_W-1:0] raddr_d,
    output logic [XLEN-1:0]       rdata_s,
    output logic [XLEN-1:0]       rdata_t,
    output logic [XLEN-1:0]       rdata_d
);
    localparam int NUM_REGS = 2**REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NUM_REGS-1]; // r0 has no storage

    assign rdata_s = (raddr_s == '0) ? '0 : regs[raddr_s];
    assign rdata_t = (raddr_t == '0) ? '0 : regs[raddr_t];
    assign rdata_d = (raddr_d == '0) ? '0 : regs[raddr_d];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== tinker_decoder.sv ====
`timescale 1ns/1ps

module tinker_decoder import tinker_pkg::*; (
    input  instr_u                instr,
    output opcode_e               opcode,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [REG_ADDR_W-1:0] rs,
    output logic [REG_ADDR_W-1:0] rt,
    output logic [XLEN-1:0]       imm,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_branch,
    output logic                  is_halt,
    output logic                  writes_rd,
    output logic                  use_literal
);
    assign opcode = opcode_e'(instr.r.opcode);

    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_halt   = (opcode == OP_HALT);
    assign is_branch = opcode inside {OP_BR, OP_BRR_R, OP_BRR_L, OP_BRNZ, OP_BRGT};

    assign use_literal = opcode inside {OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI,
                                        OP_MOV_L, OP_LOAD, OP_STORE, OP_BRR_L};

    assign writes_rd = opcode inside {OP_AND, OP_OR, OP_XOR, OP_NOT,
                                      OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
                                      OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL,
                                      OP_MOV_R, OP_MOV_L, OP_LOAD};

    always_comb begin
        rd = instr.r.rd;
        rs = instr.r.rs;
        if (use_literal) begin
            rt  = '0;
            imm = {{(XLEN-IMM_W){instr.l.imm[IMM_W-1]}}, instr.l.imm};
        end else begin
            rt  = instr.r.rt;
            imm = '0;
        end
        // addi and subi accumulate into rd
        if (opcode == OP_ADDI || opcode == OP_SUBI) begin
            rs = instr.l.rd;
        end
    end

endmodule

// ==== tinker_pkg.sv ====
package tinker_pkg;

    localparam int XLEN        = 64;
    localparam int ILEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int OPCODE_W    = 5;
    localparam int IMM_W       = 12;

    localparam logic [XLEN-1:0] RESET_PC    = 64'h2000;
    localparam logic [XLEN-1:0] INSTR_BYTES = 64'd4;

    // div, call and return have no encoding here and run as no-ops
    typedef enum logic [OPCODE_W-1:0] {
        OP_AND    = 5'b00000,
        OP_OR     = 5'b00001,
        OP_XOR    = 5'b00010,
        OP_NOT    = 5'b00011,
        OP_SHFTR  = 5'b00100,
        OP_SHFTRI = 5'b00101,
        OP_SHFTL  = 5'b00110,
        OP_SHFTLI = 5'b00111,
        OP_BR     = 5'b01000,
        OP_BRR_R  = 5'b01001, // pc + rd
        OP_BRR_L  = 5'b01010, // pc + literal
        OP_BRNZ   = 5'b01011,
        OP_BRGT   = 5'b01110,
        OP_LOAD   = 5'b10000,
        OP_MOV_R  = 5'b10001,
        OP_MOV_L  = 5'b10010,
        OP_STORE  = 5'b10011,
        OP_ADD    = 5'b11000,
        OP_ADDI   = 5'b11001,
        OP_SUB    = 5'b11010,
        OP_SUBI   = 5'b11011,
        OP_MUL    = 5'b11100,
        OP_HALT   = 5'b11111
    } opcode_e;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [11:0]           unused;
    } instr_reg_t;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs;
        logic [4:0]            unused;
        logic [IMM_W-1:0]      imm;
    } instr_lit_t;

    typedef union packed {
        instr_reg_t r;
        instr_lit_t l;
    } instr_u;

    typedef struct packed {
        logic            write;
        logic            word;  // 1 for 8-byte word, 0 for 4-byte instruction
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALTED
    } state_e;

endpackage
